/* src/rv_pkg.sv */
package rv_pkg;

	// one instruction walks through all five sequencer states
	typedef enum logic [2:0] {
		ST_PC,
		ST_IMR,
		ST_IDRFR,
		ST_EX,
		ST_DMRW
	} cpu_stat_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_t;

	localparam logic [6:0] OP_LUI   = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_ALUI  = 7'b0010011;
	localparam logic [6:0] OP_ALU   = 7'b0110011;
	localparam logic [6:0] OP_LD    = 7'b0000011;
	localparam logic [6:0] OP_ST    = 7'b0100011;
	localparam logic [6:0] OP_BR    = 7'b1100011;
	localparam logic [6:0] OP_JAL   = 7'b1101111;
	localparam logic [6:0] OP_JALR  = 7'b1100111;

	typedef struct packed {
		logic lui;
		logic auipc;
		logic alui;
		logic alu;
		logic ld;
		logic st;
		logic br;
		logic jal;
		logic jalr;
		alu_op_t alu_op;
		logic [2:0] br_code; // funct3 of the branch
		logic [4:0] rs1_adr;
		logic [4:0] rs2_adr;
		logic [4:0] rd_adr;
		logic wbk_rd_reg;
		logic [31:0] imm; // already sign extended
	} dec_cmd_t;

	typedef struct packed {
		logic cmd_ld;
		logic cmd_st;
		logic wbk_rd_reg;
		logic [4:0] rd_adr;
		logic [31:0] rd_data; // alu result, link or ld/st address
		logic [31:0] st_data;
	} ma_req_t;

	typedef struct packed {
		logic wbk_rd_reg;
		logic [4:0] rd_adr;
		logic [31:0] wbk_data;
	} wb_t;

endpackage

/* src/cpu_state_machine.sv */
module cpu_state_machine (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_cpu_start,
	input logic i_quit_cmd,
	input logic i_imr_run,
	input logic i_dmrw_run,
	output rv_pkg::cpu_stat_t o_cur_stat,
	output logic o_running
);
	import rv_pkg::*;

	cpu_stat_t next_stat;
	logic quit_pend; // quit seen mid instruction
	logic stop_now;

	assign stop_now = o_running & (o_cur_stat == ST_PC) & (quit_pend | i_quit_cmd);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_running <= 1'b0;
			quit_pend <= 1'b0;
		end else if (i_cpu_start) begin
			o_running <= 1'b1;
			quit_pend <= 1'b0;
		end else if (stop_now) begin
			o_running <= 1'b0;
			quit_pend <= 1'b0;
		end else if (i_quit_cmd) begin
			quit_pend <= 1'b1; // honoured at next ST_PC
		end
	end

	always_comb begin
		next_stat = o_cur_stat;
		case (o_cur_stat)
			ST_PC:    if (o_running & ~stop_now) next_stat = ST_IMR;
			ST_IMR:   if (~i_imr_run) next_stat = ST_IDRFR;
			ST_IDRFR: next_stat = ST_EX;
			ST_EX:    next_stat = ST_DMRW;
			ST_DMRW:  if (~i_dmrw_run) next_stat = ST_PC;
			default:  next_stat = ST_PC;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_cur_stat <= ST_PC;
		end else begin
			o_cur_stat <= next_stat;
		end
	end

endmodule

/* src/inst_mem_read.sv */
module inst_mem_read (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_cpu_start,
	input logic [31:2] i_cpu_start_adr,
	input rv_pkg::cpu_stat_t i_cur_stat,
	input logic i_jmp_condition,
	input logic [31:2] i_jmp_adr,
	output logic [31:2] o_pc,
	output logic [31:0] o_inst,
	output logic o_imr_run,
	output logic o_i_read_req,
	output logic [31:0] o_i_read_adr,
	input logic i_read_valid,
	input logic [31:0] i_read_data
);
	import rv_pkg::*;

	logic in_imr;
	logic wait_valid; // request sent and data pending
	logic got_inst; // last IMR cycle

	assign in_imr = (i_cur_stat == ST_IMR);
	assign o_i_read_req = in_imr & ~wait_valid & ~got_inst; // first IMR cycle only
	assign o_imr_run = in_imr & ~got_inst;
	assign o_i_read_adr = {o_pc, 2'b00}; // held for the whole read

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_pc <= 30'd0;
		end else if (i_cpu_start) begin
			o_pc <= i_cpu_start_adr;
		end else if (i_cur_stat == ST_EX) begin
			o_pc <= i_jmp_condition ? i_jmp_adr : o_pc + 30'd1;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wait_valid <= 1'b0;
			got_inst <= 1'b0;
		end else begin
			if (o_i_read_req) begin
				wait_valid <= 1'b1;
			end else if (wait_valid & i_read_valid) begin
				wait_valid <= 1'b0;
			end
			got_inst <= wait_valid & i_read_valid; // high for one cycle as the state moves on
		end
	end

	always_ff @(posedge i_clk) begin
		if (wait_valid & i_read_valid) begin
			o_inst <= i_read_data;
		end
	end

endmodule

/* src/decoder.sv */
module decoder (
	input logic [31:0] i_inst,
	output rv_pkg::dec_cmd_t o_cmd
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	assign opcode = i_inst[6:0];
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];

	assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
	assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
	assign imm_u = {i_inst[31:12], 12'd0};
	assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21],
		1'b0};

	always_comb begin
		o_cmd = '0;
		o_cmd.lui = (opcode == OP_LUI);
		o_cmd.auipc = (opcode == OP_AUIPC);
		o_cmd.alui = (opcode == OP_ALUI);
		o_cmd.alu = (opcode == OP_ALU);
		o_cmd.ld = (opcode == OP_LD); // word access only
		o_cmd.st = (opcode == OP_ST);
		o_cmd.br = (opcode == OP_BR);
		o_cmd.jal = (opcode == OP_JAL);
		o_cmd.jalr = (opcode == OP_JALR);
		o_cmd.br_code = funct3;
		o_cmd.rs1_adr = i_inst[19:15];
		o_cmd.rs2_adr = i_inst[24:20];
		o_cmd.rd_adr = i_inst[11:7];

		// address and link math all use add
		o_cmd.alu_op = ALU_ADD;
		if (o_cmd.alu | o_cmd.alui) begin
			case (funct3)
				3'b000: o_cmd.alu_op = (o_cmd.alu & funct7[5]) ? ALU_SUB : ALU_ADD;
				3'b001: o_cmd.alu_op = ALU_SLL;
				3'b010: o_cmd.alu_op = ALU_SLT;
				3'b011: o_cmd.alu_op = ALU_SLTU;
				3'b100: o_cmd.alu_op = ALU_XOR;
				3'b101: o_cmd.alu_op = funct7[5] ? ALU_SRA : ALU_SRL; // srai too
				3'b110: o_cmd.alu_op = ALU_OR;
				default: o_cmd.alu_op = ALU_AND;
			endcase
		end

		if (o_cmd.lui | o_cmd.auipc) o_cmd.imm = imm_u;
		else if (o_cmd.st) o_cmd.imm = imm_s;
		else if (o_cmd.br) o_cmd.imm = imm_b;
		else if (o_cmd.jal) o_cmd.imm = imm_j;
		else o_cmd.imm = imm_i; // shamt sits in imm[4:0]

		// x0 as destination writes nothing
		o_cmd.wbk_rd_reg = (o_cmd.lui | o_cmd.auipc | o_cmd.alui | o_cmd.alu | o_cmd.ld |
			o_cmd.jal | o_cmd.jalr) & (o_cmd.rd_adr != 5'd0);
	end

endmodule

/* src/register_file.sv */
module register_file (
	input logic i_clk,
	input logic i_rst_n,
	input logic [4:0] i_rs1_adr,
	input logic [4:0] i_rs2_adr,
	input rv_pkg::wb_t i_wb,
	input rv_pkg::cpu_stat_t i_cur_stat,
	output logic [31:0] o_rs1_data,
	output logic [31:0] o_rs2_data
);
	import rv_pkg::*;

	logic [31:0] regs [1:31]; // x0 not stored

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if ((i_cur_stat == ST_DMRW) & i_wb.wbk_rd_reg & (i_wb.rd_adr != 5'd0)) begin
			regs[i_wb.rd_adr] <= i_wb.wbk_data;
		end
	end

	// operands sampled once per instruction
	always_ff @(posedge i_clk) begin
		if (i_cur_stat == ST_IDRFR) begin
			o_rs1_data <= (i_rs1_adr == 5'd0) ? 32'd0 : regs[i_rs1_adr];
			o_rs2_data <= (i_rs2_adr == 5'd0) ? 32'd0 : regs[i_rs2_adr];
		end
	end

endmodule

/* src/execution.sv */
module execution (
	input logic i_clk,
	input logic i_rst_n,
	input rv_pkg::cpu_stat_t i_cur_stat,
	input rv_pkg::dec_cmd_t i_cmd,
	input logic [31:2] i_pc,
	input logic [31:0] i_rs1_data,
	input logic [31:0] i_rs2_data,
	output rv_pkg::ma_req_t o_ma_req,
	output logic o_jmp_condition,
	output logic [31:2] o_jmp_adr
);
	import rv_pkg::*;

	logic [31:0] pc32;
	logic [31:0] link_adr; // pc + 4
	logic [31:0] op2;
	logic [31:0] alu_res;
	logic [31:0] rd_data;
	logic [31:0] jmp_target;
	logic br_taken;

	assign pc32 = {i_pc, 2'b00};
	assign link_adr = pc32 + 32'd4;
	assign op2 = i_cmd.alu ? i_rs2_data : i_cmd.imm;

	always_comb begin
		case (i_cmd.alu_op)
			ALU_ADD:  alu_res = i_rs1_data + op2;
			ALU_SUB:  alu_res = i_rs1_data - op2;
			ALU_SLL:  alu_res = i_rs1_data << op2[4:0];
			ALU_SLT:  alu_res = {31'd0, $signed(i_rs1_data) < $signed(op2)};
			ALU_SLTU: alu_res = {31'd0, i_rs1_data < op2};
			ALU_XOR:  alu_res = i_rs1_data ^ op2;
			ALU_SRL:  alu_res = i_rs1_data >> op2[4:0];
			ALU_SRA:  alu_res = $signed(i_rs1_data) >>> op2[4:0];
			ALU_OR:   alu_res = i_rs1_data | op2;
			default:  alu_res = i_rs1_data & op2;
		endcase
	end

	always_comb begin
		case (i_cmd.br_code)
			3'b000:  br_taken = (i_rs1_data == i_rs2_data); // beq
			3'b001:  br_taken = (i_rs1_data != i_rs2_data); // bne
			3'b100:  br_taken = $signed(i_rs1_data) < $signed(i_rs2_data);
			3'b101:  br_taken = $signed(i_rs1_data) >= $signed(i_rs2_data);
			3'b110:  br_taken = i_rs1_data < i_rs2_data;
			3'b111:  br_taken = i_rs1_data >= i_rs2_data;
			default: br_taken = 1'b0;
		endcase
	end

	assign rd_data = i_cmd.lui ? i_cmd.imm :
		i_cmd.auipc ? pc32 + i_cmd.imm :
		(i_cmd.jal | i_cmd.jalr) ? link_adr : alu_res;

	assign jmp_target = i_cmd.jalr ? ((i_rs1_data + i_cmd.imm) & ~32'd1) : pc32 + i_cmd.imm;
	assign o_jmp_condition = i_cmd.jal | i_cmd.jalr | (i_cmd.br & br_taken);
	assign o_jmp_adr = jmp_target[31:2];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ma_req <= '0;
		end else if (i_cur_stat == ST_EX) begin
			o_ma_req.cmd_ld <= i_cmd.ld;
			o_ma_req.cmd_st <= i_cmd.st;
			o_ma_req.wbk_rd_reg <= i_cmd.wbk_rd_reg;
			o_ma_req.rd_adr <= i_cmd.rd_adr;
			o_ma_req.rd_data <= rd_data;
			o_ma_req.st_data <= i_rs2_data;
		end
	end

endmodule

/* src/data_rw_mem.sv */
module data_rw_mem (
	input logic i_clk,
	input logic i_rst_n,
	input rv_pkg::cpu_stat_t i_cur_stat,
	input rv_pkg::ma_req_t i_ma_req,
	output rv_pkg::wb_t o_wb,
	output logic o_dmrw_run,
	output logic o_d_read_req,
	output logic [31:0] o_d_read_adr,
	input logic i_read_valid,
	input logic [31:0] i_read_data,
	output logic o_d_write_req,
	output logic [31:0] o_d_write_adr,
	output logic [31:0] o_d_write_data,
	input logic i_write_finish
);
	import rv_pkg::*;

	logic mem_acc; // ld or st in DMRW
	logic first_cyc;
	logic wait_done;
	logic acc_done; // last DMRW cycle of a ld/st
	logic finish;
	logic [31:0] ld_data;

	assign mem_acc = (i_cur_stat == ST_DMRW) & (i_ma_req.cmd_ld | i_ma_req.cmd_st);
	assign first_cyc = mem_acc & ~wait_done & ~acc_done;
	assign finish = i_ma_req.cmd_ld ? i_read_valid : i_write_finish;

	assign o_d_read_req = first_cyc & i_ma_req.cmd_ld;
	assign o_d_write_req = first_cyc & i_ma_req.cmd_st;
	assign o_d_read_adr = i_ma_req.rd_data;
	assign o_d_write_adr = i_ma_req.rd_data;
	assign o_d_write_data = i_ma_req.st_data;
	assign o_dmrw_run = mem_acc & ~acc_done;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wait_done <= 1'b0;
			acc_done <= 1'b0;
		end else begin
			if (first_cyc) begin
				wait_done <= 1'b1;
			end else if (wait_done & finish) begin
				wait_done <= 1'b0;
			end
			acc_done <= wait_done & finish;
		end
	end

	always_ff @(posedge i_clk) begin
		if (wait_done & i_read_valid & i_ma_req.cmd_ld) begin
			ld_data <= i_read_data;
		end
	end

	// write only once the loaded word is in
	assign o_wb.wbk_rd_reg = i_ma_req.wbk_rd_reg & ~o_dmrw_run;
	assign o_wb.rd_adr = i_ma_req.rd_adr;
	assign o_wb.wbk_data = i_ma_req.cmd_ld ? ld_data : i_ma_req.rd_data;

endmodule

/* src/cpu_top.sv */
module cpu_top (
	input logic clk,
	input logic i_rst_n,
	input logic i_cpu_start,
	input logic i_quit_cmd,
	input logic [31:2] i_cpu_start_adr,
	output logic [31:0] o_pc_data,
	output logic o_i_read_req,
	output logic [31:0] o_i_read_adr,
	output logic o_d_read_req,
	output logic [31:0] o_d_read_adr,
	input logic i_read_valid,
	input logic [31:0] i_read_data,
	output logic o_d_write_req,
	output logic [31:0] o_d_write_adr,
	output logic [31:0] o_d_write_data,
	input logic i_write_finish
);
	import rv_pkg::*;

	cpu_stat_t cur_stat;
	logic imr_run;
	logic dmrw_run;
	logic [31:2] pc;
	logic [31:0] inst;
	dec_cmd_t dec_cmd;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	ma_req_t ma_req;
	logic jmp_condition;
	logic [31:2] jmp_adr;
	wb_t wb;

	assign o_pc_data = {pc, 2'b00};

	cpu_state_machine cpu_state_machine (
		.i_clk(clk),
		.i_rst_n(i_rst_n),
		.i_cpu_start(i_cpu_start),
		.i_quit_cmd(i_quit_cmd),
		.i_imr_run(imr_run),
		.i_dmrw_run(dmrw_run),
		.o_cur_stat(cur_stat),
		.o_running()
	);

	inst_mem_read inst_mem_read (
		.i_clk(clk),
		.i_rst_n(i_rst_n),
		.i_cpu_start(i_cpu_start),
		.i_cpu_start_adr(i_cpu_start_adr),
		.i_cur_stat(cur_stat),
		.i_jmp_condition(jmp_condition),
		.i_jmp_adr(jmp_adr),
		.o_pc(pc),
		.o_inst(inst),
		.o_imr_run(imr_run),
		.o_i_read_req(o_i_read_req),
		.o_i_read_adr(o_i_read_adr),
		.i_read_valid(i_read_valid),
		.i_read_data(i_read_data)
	);

	decoder decoder (
		.i_inst(inst),
		.o_cmd(dec_cmd)
	);

	register_file register_file (
		.i_clk(clk),
		.i_rst_n(i_rst_n),
		.i_rs1_adr(dec_cmd.rs1_adr),
		.i_rs2_adr(dec_cmd.rs2_adr),
		.i_wb(wb),
		.i_cur_stat(cur_stat),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data)
	);

	execution execution (
		.i_clk(clk),
		.i_rst_n(i_rst_n),
		.i_cur_stat(cur_stat),
		.i_cmd(dec_cmd),
		.i_pc(pc),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.o_ma_req(ma_req),
		.o_jmp_condition(jmp_condition),
		.o_jmp_adr(jmp_adr)
	);

	data_rw_mem data_rw_mem (
		.i_clk(clk),
		.i_rst_n(i_rst_n),
		.i_cur_stat(cur_stat),
		.i_ma_req(ma_req),
		.o_wb(wb),
		.o_dmrw_run(dmrw_run),
		.o_d_read_req(o_d_read_req),
		.o_d_read_adr(o_d_read_adr),
		.i_read_valid(i_read_valid),
		.i_read_data(i_read_data),
		.o_d_write_req(o_d_write_req),
		.o_d_write_adr(o_d_write_adr),
		.o_d_write_data(o_d_write_data),
		.i_write_finish(i_write_finish)
	);

endmodule

/* tb/tb_mem_model.sv */
module tb_mem_model (
	input logic i_clk,
	input logic i_i_read_req,
	input logic [31:0] i_i_read_adr,
	input logic i_d_read_req,
	input logic [31:0] i_d_read_adr,
	output logic o_read_valid,
	output logic [31:0] o_read_data,
	input logic i_d_write_req,
	input logic [31:0] i_d_write_adr,
	input logic [31:0] i_d_write_data,
	output logic o_write_finish
);

	logic [31:0] mem [0:255]; // 1 KiB, word addressed

	initial begin
		int delay;
		logic [31:0] adr;
		logic [31:0] wdata;
		logic is_wr;
		o_read_valid = 1'b0;
		o_read_data = 32'd0;
		o_write_finish = 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = {16'hbad0, 6'd0, i[7:0], 2'b00}; // fill tracks byte address
		end
		forever begin
			@(negedge i_clk); // requests are stable mid cycle
			if (i_i_read_req | i_d_read_req | i_d_write_req) begin
				is_wr = i_d_write_req;
				adr = i_d_write_req ? i_d_write_adr : i_d_read_req ? i_d_read_adr : i_i_read_adr;
				wdata = i_d_write_data;
				delay = $urandom_range(4, 1);
				repeat (delay) @(posedge i_clk);
				#5;
				if (is_wr) begin
					mem[adr[9:2]] = wdata;
					o_write_finish = 1'b1;
				end else begin
					o_read_data = mem[adr[9:2]];
					o_read_valid = 1'b1;
				end
				@(posedge i_clk);
				#5;
				o_read_valid = 1'b0; // single cycle answer
				o_write_finish = 1'b0;
			end
		end
	end

endmodule

/* tb/tb_cpu_top.sv */
module tb_cpu_top;

	localparam int NUM_INST = 42;
	localparam int NUM_ST = 12;
	localparam logic [31:0] PROG_BASE = 32'h40;
	localparam logic [31:0] FINAL_PC = 32'he4; // self loop at the end
	localparam int QUIET = 40; // idle cycles that mean the core stopped
	// worst instruction is 1 + 6 fetch + 2 + 6 data access plus slack
	localparam int LIMIT = NUM_INST * 16 + 50 + QUIET;
	localparam logic [6:0] OPI = 7'h13;

	logic clk;
	logic rst_n;
	logic cpu_start;
	logic quit_cmd;
	logic [31:2] cpu_start_adr;
	logic [31:0] pc_data;
	logic i_read_req;
	logic [31:0] i_read_adr;
	logic d_read_req;
	logic [31:0] d_read_adr;
	logic read_valid;
	logic [31:0] read_data;
	logic d_write_req;
	logic [31:0] d_write_adr;
	logic [31:0] d_write_data;
	logic write_finish;

	logic [31:0] prog [NUM_INST];
	logic [31:0] exp_adr [NUM_ST];
	logic [31:0] exp_data [NUM_ST];
	int st_idx = 0;
	int quiet_cnt = 0;
	int cycle_cnt = 0;
	bit fetch_seen = 0;
	bit quit_sent = 0;

	cpu_top dut_i (
		.clk(clk), .i_rst_n(rst_n), .i_cpu_start(cpu_start), .i_quit_cmd(quit_cmd),
		.i_cpu_start_adr(cpu_start_adr), .o_pc_data(pc_data),
		.o_i_read_req(i_read_req), .o_i_read_adr(i_read_adr),
		.o_d_read_req(d_read_req), .o_d_read_adr(d_read_adr),
		.i_read_valid(read_valid), .i_read_data(read_data),
		.o_d_write_req(d_write_req), .o_d_write_adr(d_write_adr),
		.o_d_write_data(d_write_data), .i_write_finish(write_finish)
	);

	tb_mem_model mem_i (
		.i_clk(clk), .i_i_read_req(i_read_req), .i_i_read_adr(i_read_adr),
		.i_d_read_req(d_read_req), .i_d_read_adr(d_read_adr),
		.o_read_valid(read_valid), .o_read_data(read_data),
		.i_d_write_req(d_write_req), .i_d_write_adr(d_write_adr),
		.i_d_write_data(d_write_data), .o_write_finish(write_finish)
	);

	function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
	endfunction

	task automatic check_store(input logic [31:0] adr, input logic [31:0] data);
		if (st_idx >= NUM_ST) begin
			$display("unexpected store of %h to address %h after the last expected one",
				data, adr);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end else if (adr !== exp_adr[st_idx] || data !== exp_data[st_idx]) begin
			$display("MISMATCH at %0t: store %0d got %h <= %h, expected %h <= %h", $time,
				st_idx, adr, data, exp_adr[st_idx], exp_data[st_idx]);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end else begin
			st_idx++;
		end
	endtask

	task automatic check_pc(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		forever begin
			@(posedge clk);
			cycle_cnt++;
			if (cycle_cnt > LIMIT) begin
				$display("timeout: core did not finish the program within %0d cycles", LIMIT);
				$display("TESTBENCH FAILED");
				$fatal(1);
			end
		end
	end

	// bus monitor sampled mid cycle
	always @(negedge clk) begin
		if (i_read_req | d_read_req | d_write_req) quiet_cnt = 0;
		else quiet_cnt++;
		if (quit_sent && (i_read_req | d_read_req | d_write_req)) begin
			$display("memory request seen after the quit command");
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
		if (i_read_req && !fetch_seen) begin
			fetch_seen = 1;
			check_pc(i_read_adr, PROG_BASE, "first fetch address");
		end
		if (d_write_req) check_store(d_write_adr, d_write_data);
	end

	initial begin
		prog[0] = enc_i(512, 0, 0, 10, OPI); // x10 = data base 0x200
		prog[1] = enc_i(-5, 0, 0, 1, OPI);
		prog[2] = enc_i(3, 0, 0, 2, OPI);
		prog[3] = enc_r(7'h20, 2, 1, 0, 3); // sub
		prog[4] = enc_s(0, 3, 10);
		prog[5] = enc_r(7'h20, 2, 1, 5, 4); // sra
		prog[6] = enc_s(4, 4, 10);
		prog[7] = enc_r(0, 2, 1, 2, 5); // slt
		prog[8] = enc_s(8, 5, 10);
		prog[9] = enc_r(0, 2, 1, 3, 6); // sltu
		prog[10] = enc_s(12, 6, 10);
		prog[11] = {20'h12345, 5'd7, 7'h37}; // lui
		prog[12] = enc_i(12'h678, 7, 6, 7, OPI); // ori
		prog[13] = enc_s(16, 7, 10);
		prog[14] = {20'h00001, 5'd8, 7'h17}; // auipc at 0x78
		prog[15] = enc_s(20, 8, 10);
		prog[16] = enc_i(12'h401, 1, 5, 9, OPI); // srai by 1
		prog[17] = enc_i(12'h0ff, 9, 4, 9, OPI); // xori
		prog[18] = enc_s(24, 9, 10);
		prog[19] = enc_i(0, 10, 2, 11, 7'h03); // lw back first word
		prog[20] = enc_i(1, 11, 0, 0, OPI); // write to x0
		prog[21] = enc_r(0, 0, 11, 0, 12);
		prog[22] = enc_s(28, 12, 10);
		prog[23] = enc_b(8, 1, 1, 0); // beq taken
		prog[24] = enc_s(32, 2, 10);
		prog[25] = enc_b(8, 2, 1, 1); // bne taken
		prog[26] = enc_s(32, 2, 10);
		prog[27] = enc_b(8, 2, 1, 4); // blt taken
		prog[28] = enc_s(32, 2, 10);
		prog[29] = enc_b(8, 2, 1, 5); // bge not taken
		prog[30] = enc_s(32, 2, 10);
		prog[31] = enc_b(8, 2, 1, 0); // beq not taken
		prog[32] = enc_s(36, 1, 10);
		prog[33] = enc_j(8, 13); // jal at 0xc4
		prog[34] = enc_s(40, 2, 10);
		prog[35] = enc_s(40, 13, 10);
		prog[36] = enc_i(224, 0, 0, 14, OPI);
		prog[37] = enc_i(0, 14, 0, 15, 7'h67); // jalr at 0xd4 to 0xe0
		prog[38] = enc_s(44, 2, 10);
		prog[39] = enc_s(44, 2, 10);
		prog[40] = enc_s(44, 15, 10);
		prog[41] = enc_j(0, 0); // spin here
		exp_adr = '{32'h200, 32'h204, 32'h208, 32'h20c, 32'h210, 32'h214,
			32'h218, 32'h21c, 32'h220, 32'h224, 32'h228, 32'h22c};
		exp_data = '{32'hfffffff8, 32'hffffffff, 32'h1, 32'h0, 32'h12345678, 32'h1078,
			32'hffffff02, 32'hfffffff8, 32'h3, 32'hfffffffb, 32'hc8, 32'hd8};

		void'($urandom(32'h1344));
		rst_n = 1'b0;
		cpu_start = 1'b0;
		quit_cmd = 1'b0;
		cpu_start_adr = PROG_BASE[31:2];
		repeat (2) @(posedge clk);
		for (int i = 0; i < NUM_INST; i++) begin
			mem_i.mem[PROG_BASE[9:2] + i] = prog[i];
		end
		#5 rst_n = 1'b1;

		repeat (3) begin
			@(negedge clk);
			if (i_read_req | d_read_req | d_write_req) begin
				$display("memory request seen before the core was started");
				$display("TESTBENCH FAILED");
				$fatal(1);
			end
			check_pc(pc_data, 32'd0, "pc before start");
		end

		@(posedge clk);
		#5 cpu_start = 1'b1;
		@(posedge clk);
		#5 cpu_start = 1'b0;

		wait (st_idx == NUM_ST);
		@(posedge clk);
		#5 quit_cmd = 1'b1;
		quit_sent = 1;
		@(posedge clk);
		#5 quit_cmd = 1'b0;
		while (quiet_cnt < QUIET) @(posedge clk); // bus idle means halted
		check_pc(pc_data, FINAL_PC, "final pc");

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* sources.f */
src/rv_pkg.sv
src/cpu_state_machine.sv
src/inst_mem_read.sv
src/decoder.sv
src/register_file.sv
src/execution.sv
src/data_rw_mem.sv
src/cpu_top.sv
tb/tb_mem_model.sv
tb/tb_cpu_top.sv
